//--- all.f
+incdir+.
cache_pkg.sv
mem_pkg.sv
cache_array.sv
cache_port_ctrl.sv
mem_arbiter.sv
multi_cycle_memory.sv
cache_controller.sv
cache_assertions.sv
tb_cache_controller.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_cache_controller \
    -f all.f -o sim_cache_controller

output=$(./obj_dir/sim_cache_controller || true)
echo "$output"

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

//--- tb_cache_controller.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module tb_cache_controller;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int SHARED_REQS  = 150;
    localparam int SOLO_REQS    = 100;
    // Worst request waits out the other side's fill, then does its own
    localparam int REQ_CYCLES = 2 * `CACHE_WORDS * (`MEM_LATENCY + 2) + `MEM_LATENCY + 4;
    localparam longint WATCHDOG_NS = 64'd400 * REQ_CYCLES * CLK_PERIOD;

    logic                      clk;
    logic                      rst_n;
    logic                      iwrite;
    logic                      iread;
    logic                      dwrite;
    logic                      dread;
    logic [`CACHE_ADDR_W-1:0]  iaddress;
    logic [`CACHE_ADDR_W-1:0]  daddress;
    logic [`CACHE_DATA_W-1:0]  idata_in;
    logic [`CACHE_DATA_W-1:0]  data_in;
    logic                      fetch_stall;
    logic                      mem_stall;
    logic                      icache_hit;
    logic                      dcache_hit;
    logic [`CACHE_DATA_W-1:0]  instruction_out;
    logic [`CACHE_DATA_W-1:0]  data_out;

    integer seed = 32'h4ce0a321;
    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    int     err_mark;

    // Reference model, indexed by side (0 instruction, 1 data), way and set
    logic [`CACHE_DATA_W-1:0]  shadow  [`MEM_WORDS];
    logic [`CACHE_TAG_W-1:0]   tag_m   [2][2][`CACHE_SETS];
    logic                      valid_m [2][2][`CACHE_SETS];
    logic                      lru_m   [2][`CACHE_SETS];

    cache_controller u_dut (
        .clk(clk), .rst_n(rst_n), .iwrite(iwrite), .iread(iread),
        .dwrite(dwrite), .dread(dread), .iaddress(iaddress), .daddress(daddress),
        .idata_in(idata_in), .data_in(data_in),
        .fetch_stall(fetch_stall), .mem_stall(mem_stall),
        .icache_hit(icache_hit), .dcache_hit(dcache_hit),
        .instruction_out(instruction_out), .data_out(data_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_NS + RESET_CYCLES * CLK_PERIOD);
        $display("watchdog expired at %0t, a request never completed", $time);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic stall_of(input int side);
        return (side == 1) ? mem_stall : fetch_stall;
    endfunction

    function automatic logic hit_of(input int side);
        return (side == 1) ? dcache_hit : icache_hit;
    endfunction

    function automatic logic [`CACHE_DATA_W-1:0] rdata_of(input int side);
        return (side == 1) ? data_out : instruction_out;
    endfunction

    task automatic drive_side(input int side, input logic rd, input logic wr,
                              input logic [15:0] addr, input logic [15:0] wdata);
        if (side == 1) begin
            dread    = rd;
            dwrite   = wr;
            daddress = addr;
            data_in  = wdata;
        end else begin
            iread    = rd;
            iwrite   = wr;
            iaddress = addr;
            idata_in = wdata;
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the completing edge
    task automatic access(input int side, input bit is_wr, input logic [15:0] addr,
                          input logic [15:0] wdata);
        logic [`CACHE_TAG_W-1:0]   tag;
        logic [`CACHE_SET_BITS-1:0] set;
        logic [14:0]               waddr;
        bit                        pred_hit;
        int                        way;
        tag      = addr[15:10];
        set      = addr[9:4];
        waddr    = addr[15:1];
        pred_hit = 1'b0;
        way      = 0;
        for (int w = 0; w < 2; w++) begin
            if (valid_m[side][w][set] && (tag_m[side][w][set] == tag)) begin
                pred_hit = 1'b1;
                way      = w;
            end
        end
        drive_side(side, !is_wr, is_wr, addr, wdata);
        @(negedge clk);
        check_value(side ? "dcache_hit" : "icache_hit", hit_of(side), pred_hit);
        check_value(side ? "mem_stall" : "fetch_stall", stall_of(side), is_wr || !pred_hit);
        while (stall_of(side)) begin
            @(negedge clk);
        end
        if (!is_wr) begin
            check_value(side ? "data_out" : "instruction_out", rdata_of(side), shadow[waddr]);
        end
        if (!pred_hit) begin
            if (!valid_m[side][0][set]) begin
                way = 0;
            end else if (!valid_m[side][1][set]) begin
                way = 1;
            end else begin
                way = lru_m[side][set];
            end
            valid_m[side][way][set] = 1'b1;
            tag_m[side][way][set]   = tag;
        end
        lru_m[side][set] = (way == 0);
        if (is_wr) begin
            shadow[waddr] = wdata;
        end
        @(posedge clk);
        #1;
        drive_side(side, 1'b0, 1'b0, addr, wdata);
    endtask

    // Three tags per side over eight sets keeps hits and evictions frequent
    task automatic run_random(input int side, input int count);
        logic [31:0]              r;
        logic [15:0]              wdata;
        logic [`CACHE_TAG_W-1:0]  tag;
        for (int n = 0; n < count; n++) begin
            r     = $random(seed);
            wdata = $random(seed);
            tag   = 6'(r[7:0] % 8'd3);
            tag[5] = (side == 1);
            access(side, r[17:16] == 2'b00, {tag, 3'b000, r[10:8], r[13:11], 1'b0}, wdata);
        end
    endtask

    task automatic write_through_evict(input int side);
        logic [5:0]  tag_hi;
        logic [15:0] addr_a;
        tag_hi = (side == 1) ? 6'h20 : 6'h00;
        addr_a = {tag_hi, 6'd12, 3'd5, 1'b0};
        access(side, 1'b1, addr_a, (side == 1) ? 16'hd00d : 16'h1ee7);
        access(side, 1'b0, addr_a, 16'h0000);
        access(side, 1'b0, {tag_hi | 6'd1, 6'd12, 3'd0, 1'b0}, 16'h0000);
        access(side, 1'b0, {tag_hi | 6'd2, 6'd12, 3'd7, 1'b0}, 16'h0000);
        // Block of addr_a was evicted, so this refills from memory
        access(side, 1'b0, addr_a, 16'h0000);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
        end
        $display("test %-22s %s, %0d errors", name,
                 (errors == err_mark) ? "ok" : "failing", errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_mark     = 0;
        drive_side(0, 1'b0, 1'b0, 16'h0000, 16'h0000);
        drive_side(1, 1'b0, 1'b0, 16'h0000, 16'h0000);
        for (int a = 0; a < `MEM_WORDS; a++) begin
            shadow[a] = a[15:0] ^ `MEM_INIT_KEY;
        end
        for (int s = 0; s < `CACHE_SETS; s++) begin
            for (int side = 0; side < 2; side++) begin
                valid_m[side][0][s] = 1'b0;
                valid_m[side][1][s] = 1'b0;
                lru_m[side][s]      = 1'b0;
            end
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("fetch_stall", fetch_stall, 1'b0);
        check_value("mem_stall", mem_stall, 1'b0);
        finish_test("reset_state");
        @(posedge clk);
        #1;

        // Both sides start cold, so the first requests miss together
        fork
            run_random(0, SHARED_REQS);
            run_random(1, SHARED_REQS);
        join
        finish_test("shared_memory_random");

        write_through_evict(0);
        write_through_evict(1);
        finish_test("write_through_evict");

        run_random(0, SOLO_REQS);
        finish_test("icache_random");
        run_random(1, SOLO_REQS);
        finish_test("dcache_random");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- cache_assertions.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_assertions (
    input logic clk,
    input logic rst_n,
    input logic m_enable,
    input logic m_valid,
    input logic i_gnt,
    input logic d_gnt,
    input logic i_busy,
    input logic d_busy,
    input logic fetch_stall,
    input logic mem_stall
);

    // Enables of the last MEM_LATENCY cycles, newest in bit 0
    logic [`MEM_LATENCY-1:0] enable_hist;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable_hist <= '0;
        end else begin
            enable_hist <= {enable_hist[`MEM_LATENCY-2:0], m_enable};
        end
    end

    no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        m_enable |-> (enable_hist == '0))
        else $error("memory enable while an access is outstanding");

    valid_timing: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid == enable_hist[`MEM_LATENCY-1])
        else $error("data_valid not exactly MEM_LATENCY cycles after enable");

    // Busy is checked too, as the stalls are masked by the request levels
    reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> (!fetch_stall && !mem_stall && !i_busy && !d_busy &&
                          !m_enable && !i_gnt && !d_gnt))
        else $error("stall, busy, enable or grant active in the first cycle after reset");

endmodule

bind cache_controller cache_assertions u_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .m_enable    (m_enable),
    .m_valid     (m_valid),
    .i_gnt       (i_gnt),
    .d_gnt       (d_gnt),
    .i_busy      (i_busy),
    .d_busy      (d_busy),
    .fetch_stall (fetch_stall),
    .mem_stall   (mem_stall)
);

//--- cache_controller.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_controller (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      iwrite,
    input  logic                      iread,
    input  logic                      dwrite,
    input  logic                      dread,
    input  logic [`CACHE_ADDR_W-1:0]  iaddress,
    input  logic [`CACHE_ADDR_W-1:0]  daddress,
    input  logic [`CACHE_DATA_W-1:0]  idata_in,
    input  logic [`CACHE_DATA_W-1:0]  data_in,
    output logic                      fetch_stall,
    output logic                      mem_stall,
    output logic                      icache_hit,
    output logic                      dcache_hit,
    output logic [`CACHE_DATA_W-1:0]  instruction_out,
    output logic [`CACHE_DATA_W-1:0]  data_out
);

    logic                      i_busy, i_req, i_start, i_gnt, i_valid;
    logic                      d_busy, d_req, d_start, d_gnt, d_valid;
    mem_pkg::mem_op_e          i_op, d_op;
    logic [`CACHE_ADDR_W-1:0]  i_addr, d_addr, m_addr;
    logic [`CACHE_DATA_W-1:0]  i_wdata, d_wdata, i_rdata, d_rdata;
    logic [`CACHE_DATA_W-1:0]  m_wdata, m_rdata;
    logic                      m_enable, m_wr, m_valid;

    // Stall only a side that is actually asking
    assign fetch_stall = (iread || iwrite) && i_busy;
    assign mem_stall   = (dread || dwrite) && d_busy;

    cache_port_ctrl u_icache (
        .clk(clk), .rst_n(rst_n), .read(iread), .write(iwrite),
        .addr(iaddress), .wdata(idata_in),
        .busy(i_busy), .hit(icache_hit), .rdata(instruction_out),
        .mem_req(i_req), .mem_start(i_start), .mem_op(i_op),
        .mem_addr(i_addr), .mem_wdata(i_wdata),
        .mem_gnt(i_gnt), .mem_valid(i_valid), .mem_rdata(i_rdata)
    );

    cache_port_ctrl u_dcache (
        .clk(clk), .rst_n(rst_n), .read(dread), .write(dwrite),
        .addr(daddress), .wdata(data_in),
        .busy(d_busy), .hit(dcache_hit), .rdata(data_out),
        .mem_req(d_req), .mem_start(d_start), .mem_op(d_op),
        .mem_addr(d_addr), .mem_wdata(d_wdata),
        .mem_gnt(d_gnt), .mem_valid(d_valid), .mem_rdata(d_rdata)
    );

    mem_arbiter u_arb (
        .clk(clk), .rst_n(rst_n),
        .i_req(i_req), .i_start(i_start), .i_op(i_op), .i_addr(i_addr), .i_wdata(i_wdata),
        .i_gnt(i_gnt), .i_valid(i_valid), .i_rdata(i_rdata),
        .d_req(d_req), .d_start(d_start), .d_op(d_op), .d_addr(d_addr), .d_wdata(d_wdata),
        .d_gnt(d_gnt), .d_valid(d_valid), .d_rdata(d_rdata),
        .mem_enable(m_enable), .mem_wr(m_wr), .mem_addr(m_addr), .mem_wdata(m_wdata),
        .mem_valid(m_valid), .mem_rdata(m_rdata)
    );

    multi_cycle_memory u_mem (
        .clk(clk), .rst_n(rst_n), .enable(m_enable), .wr(m_wr),
        .addr(m_addr), .data_in(m_wdata),
        .data_out(m_rdata), .data_valid(m_valid)
    );

endmodule

//--- multi_cycle_memory.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module multi_cycle_memory (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      enable,
    input  logic                      wr,
    input  logic [`CACHE_ADDR_W-1:0]  addr,
    input  logic [`CACHE_DATA_W-1:0]  data_in,
    output logic [`CACHE_DATA_W-1:0]  data_out,
    output logic                      data_valid
);

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);
    localparam logic [CNT_W-1:0] LATENCY = `MEM_LATENCY;

    logic [`CACHE_DATA_W-1:0]  mem [`MEM_WORDS];
    logic [CNT_W-1:0]          count;
    logic                      wr_q;
    logic [`CACHE_ADDR_W-2:0]  waddr_q;
    logic [`CACHE_DATA_W-1:0]  wdata_q;

    initial begin
        for (int a = 0; a < `MEM_WORDS; a++) begin
            mem[a] = a[`CACHE_DATA_W-1:0] ^ `MEM_INIT_KEY;
        end
    end

    // Count of 1 marks the completing cycle
    assign data_valid = (count == 1);
    assign data_out   = mem[waddr_q];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (count != 0) begin
            count <= count - 1'b1;
        end else if (enable) begin
            count <= LATENCY;
        end
    end

    always_ff @(posedge clk) begin
        if ((count == 0) && enable) begin
            wr_q    <= wr;
            waddr_q <= addr[`CACHE_ADDR_W-1:1];
            wdata_q <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (data_valid && wr_q) begin
            mem[waddr_q] <= wdata_q;
        end
    end

endmodule

//--- mem_arbiter.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module mem_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_req,
    input  logic                      i_start,
    input  mem_pkg::mem_op_e          i_op,
    input  logic [`CACHE_ADDR_W-1:0]  i_addr,
    input  logic [`CACHE_DATA_W-1:0]  i_wdata,
    output logic                      i_gnt,
    output logic                      i_valid,
    output logic [`CACHE_DATA_W-1:0]  i_rdata,
    input  logic                      d_req,
    input  logic                      d_start,
    input  mem_pkg::mem_op_e          d_op,
    input  logic [`CACHE_ADDR_W-1:0]  d_addr,
    input  logic [`CACHE_DATA_W-1:0]  d_wdata,
    output logic                      d_gnt,
    output logic                      d_valid,
    output logic [`CACHE_DATA_W-1:0]  d_rdata,
    output logic                      mem_enable,
    output logic                      mem_wr,
    output logic [`CACHE_ADDR_W-1:0]  mem_addr,
    output logic [`CACHE_DATA_W-1:0]  mem_wdata,
    input  logic                      mem_valid,
    input  logic [`CACHE_DATA_W-1:0]  mem_rdata
);

    mem_pkg::grant_e owner;

    // Instruction side wins when both ask in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner <= mem_pkg::GRANT_NONE;
        end else begin
            case (owner)
                mem_pkg::GRANT_I: if (!i_req) owner <= mem_pkg::GRANT_NONE;
                mem_pkg::GRANT_D: if (!d_req) owner <= mem_pkg::GRANT_NONE;
                default: begin
                    if (i_req) begin
                        owner <= mem_pkg::GRANT_I;
                    end else if (d_req) begin
                        owner <= mem_pkg::GRANT_D;
                    end
                end
            endcase
        end
    end

    assign i_gnt = (owner == mem_pkg::GRANT_I);
    assign d_gnt = (owner == mem_pkg::GRANT_D);

    assign mem_enable = (i_gnt && i_start) || (d_gnt && d_start);
    assign mem_wr     = d_gnt ? (d_op == mem_pkg::MEM_WRITE) : (i_op == mem_pkg::MEM_WRITE);
    assign mem_addr   = d_gnt ? d_addr : i_addr;
    assign mem_wdata  = d_gnt ? d_wdata : i_wdata;

    // Responses go to the owner only
    assign i_valid = i_gnt && mem_valid;
    assign d_valid = d_gnt && mem_valid;
    assign i_rdata = i_gnt ? mem_rdata : '0;
    assign d_rdata = d_gnt ? mem_rdata : '0;

endmodule

//--- cache_port_ctrl.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_port_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      read,
    input  logic                      write,
    input  logic [`CACHE_ADDR_W-1:0]  addr,
    input  logic [`CACHE_DATA_W-1:0]  wdata,
    output logic                      busy,
    output logic                      hit,
    output logic [`CACHE_DATA_W-1:0]  rdata,
    output logic                      mem_req,
    output logic                      mem_start,
    output mem_pkg::mem_op_e          mem_op,
    output logic [`CACHE_ADDR_W-1:0]  mem_addr,
    output logic [`CACHE_DATA_W-1:0]  mem_wdata,
    input  logic                      mem_gnt,
    input  logic                      mem_valid,
    input  logic [`CACHE_DATA_W-1:0]  mem_rdata
);

    localparam cache_pkg::word_idx_t LAST_WORD = cache_pkg::word_idx_t'(`CACHE_WORDS - 1);

    cache_pkg::port_state_e    state;
    cache_pkg::word_idx_t      fill_cnt;
    cache_pkg::way_t           cur_way;
    cache_pkg::way_t           arr_hit_way;
    cache_pkg::way_t           arr_victim;
    cache_pkg::way_t           touch_way;
    cache_pkg::word_idx_t      data_word;
    logic [`CACHE_DATA_W-1:0]  data_wdata;
    logic                      outstanding;
    logic                      arr_hit;
    logic                      req;
    logic                      filling;
    logic                      data_we;
    logic                      tag_we;
    logic                      touch;

    assign req     = read | write;
    assign hit     = req & arr_hit;
    assign filling = (state == cache_pkg::FILL);

    // Ownership is held across fill and write-through
    assign mem_req   = filling || (state == cache_pkg::WRITE_THRU);
    assign mem_start = mem_req && mem_gnt && !outstanding;
    assign mem_op    = (state == cache_pkg::WRITE_THRU) ? mem_pkg::MEM_WRITE : mem_pkg::MEM_READ;
    assign mem_addr  = filling ? {addr[`CACHE_ADDR_W-1:`CACHE_SET_LSB], fill_cnt, 1'b0} : addr;
    assign mem_wdata = wdata;

    // Array updates land on the memory valid pulse
    assign data_we    = mem_req && mem_valid;
    assign data_word  = filling ? fill_cnt : addr[`CACHE_SET_LSB-1:`CACHE_WORD_LSB];
    assign data_wdata = filling ? mem_rdata : wdata;
    assign tag_we     = filling && mem_valid && (fill_cnt == LAST_WORD);

    assign touch     = (state == cache_pkg::DONE) ||
                       ((state == cache_pkg::IDLE) && read && !write && arr_hit);
    assign touch_way = (state == cache_pkg::DONE) ? cur_way : arr_hit_way;

    always_comb begin
        case (state)
            cache_pkg::IDLE:       busy = write || (read && !arr_hit);
            cache_pkg::FILL:       busy = 1'b1;
            cache_pkg::WRITE_THRU: busy = 1'b1;
            default:               busy = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= cache_pkg::IDLE;
            fill_cnt    <= '0;
            outstanding <= 1'b0;
        end else begin
            if (mem_start) begin
                outstanding <= 1'b1;
            end else if (mem_valid) begin
                outstanding <= 1'b0;
            end
            case (state)
                cache_pkg::IDLE: begin
                    if (write && arr_hit) begin
                        state <= cache_pkg::WRITE_THRU;
                    end else if (req && !arr_hit) begin
                        state    <= cache_pkg::FILL;
                        fill_cnt <= '0;
                    end
                end
                cache_pkg::FILL: begin
                    if (mem_valid) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        // Write miss goes straight on to the write-through
                        if (fill_cnt == LAST_WORD) begin
                            state <= write ? cache_pkg::WRITE_THRU : cache_pkg::IDLE;
                        end
                    end
                end
                cache_pkg::WRITE_THRU: begin
                    if (mem_valid) begin
                        state <= cache_pkg::DONE;
                    end
                end
                default: state <= cache_pkg::IDLE;
            endcase
        end
    end

    // Way is frozen once the controller leaves IDLE
    always_ff @(posedge clk) begin
        if (state == cache_pkg::IDLE) begin
            cur_way <= arr_hit ? arr_hit_way : arr_victim;
        end
    end

    cache_array u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (addr),
        .hit        (arr_hit),
        .hit_way    (arr_hit_way),
        .victim_way (arr_victim),
        .rdata      (rdata),
        .data_we    (data_we),
        .data_way   (cur_way),
        .data_word  (data_word),
        .data_wdata (data_wdata),
        .tag_we     (tag_we),
        .tag_way    (cur_way),
        .tag_value  (addr[`CACHE_ADDR_W-1:`CACHE_TAG_LSB]),
        .touch      (touch),
        .touch_way  (touch_way)
    );

endmodule

//--- cache_array.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_array (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`CACHE_ADDR_W-1:0]  addr,
    output logic                      hit,
    output cache_pkg::way_t           hit_way,
    output cache_pkg::way_t           victim_way,
    output logic [`CACHE_DATA_W-1:0]  rdata,
    input  logic                      data_we,
    input  cache_pkg::way_t           data_way,
    input  cache_pkg::word_idx_t      data_word,
    input  logic [`CACHE_DATA_W-1:0]  data_wdata,
    input  logic                      tag_we,
    input  cache_pkg::way_t           tag_way,
    input  cache_pkg::tag_t           tag_value,
    input  logic                      touch,
    input  cache_pkg::way_t           touch_way
);

    localparam int LINES = `CACHE_SETS * `CACHE_WORDS;

    cache_pkg::tag_t           tag_mem  [2][`CACHE_SETS];
    logic [1:0]                valid    [`CACHE_SETS];
    logic [`CACHE_SETS-1:0]    lru;
    logic [`CACHE_DATA_W-1:0]  data_mem [2][LINES];

    cache_pkg::set_t           set;
    cache_pkg::word_idx_t      word;
    cache_pkg::tag_t           tag;
    logic [1:0]                way_match;

    assign set  = addr[`CACHE_TAG_LSB-1:`CACHE_SET_LSB];
    assign word = addr[`CACHE_SET_LSB-1:`CACHE_WORD_LSB];
    assign tag  = addr[`CACHE_ADDR_W-1:`CACHE_TAG_LSB];

    // Compare against both ways in parallel
    assign way_match[0] = valid[set][0] && (tag_mem[0][set] == tag);
    assign way_match[1] = valid[set][1] && (tag_mem[1][set] == tag);

    assign hit     = |way_match;
    assign hit_way = way_match[1];
    assign rdata   = data_mem[hit_way][{set, word}];

    // Fill an empty way before evicting anything
    always_comb begin
        if (!valid[set][0]) begin
            victim_way = 1'b0;
        end else if (!valid[set][1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru[set];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid[s] <= 2'b00;
            end
            lru <= '0;
        end else begin
            if (tag_we) begin
                valid[set][tag_way] <= 1'b1;
            end
            // LRU bit names the next victim
            if (touch) begin
                lru[set] <= ~touch_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[tag_way][set] <= tag_value;
        end
    end

    always_ff @(posedge clk) begin
        if (data_we) begin
            data_mem[data_way][{set, data_word}] <= data_wdata;
        end
    end

endmodule

//--- mem_pkg.sv
package mem_pkg;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // Current owner of the shared memory port
    typedef enum logic [1:0] {
        GRANT_NONE = 2'd0,
        GRANT_I    = 2'd1,
        GRANT_D    = 2'd2
    } grant_e;

endpackage

//--- cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

    // Per-side miss and write-through controller
    typedef enum logic [1:0] {
        IDLE,
        FILL,
        WRITE_THRU,
        DONE
    } port_state_e;

    typedef logic way_t;

    typedef logic [`CACHE_TAG_W-1:0] tag_t;

    typedef logic [`CACHE_SET_BITS-1:0] set_t;

    // Word offset inside a block
    typedef logic [`CACHE_WORD_BITS-1:0] word_idx_t;

endpackage

//--- cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Processor word and byte address
`define CACHE_ADDR_W 16
`define CACHE_DATA_W 16

// Geometry of one cache side
`define CACHE_SETS 64
`define CACHE_SET_BITS 6
`define CACHE_WORDS 8
`define CACHE_WORD_BITS 3
`define CACHE_TAG_W 6

// Byte address field positions, bit 0 unused
`define CACHE_WORD_LSB 1
`define CACHE_SET_LSB (`CACHE_WORD_LSB + `CACHE_WORD_BITS)
`define CACHE_TAG_LSB (`CACHE_SET_LSB + `CACHE_SET_BITS)

// Main memory
`define MEM_WORDS 32768
`define MEM_LATENCY 4

// Word at word address a holds a ^ key after power-up
`define MEM_INIT_KEY 16'ha5a5

`endif
